// File: hw/alu.sv
`timescale 1ns/1ps

module alu (
	input  logic [cpuPkg::dataWidth-1:0]  op1,
	input  logic [cpuPkg::dataWidth-1:0]  op2,
	input  cpuPkg::aluFuncT               func,
	output logic [cpuPkg::dataWidth-1:0]  result,
	output logic [3:0]                    flags  // {zero, negative, carry, overflow}
);

	logic [cpuPkg::dataWidth:0] sum; // one extra bit for carry out
	logic                       carry;
	logic                       overflow;

	always_comb begin
		sum      = '0;
		carry    = 1'b0;
		overflow = 1'b0;
		case (func)
			cpuPkg::AluAdd: begin
				sum      = {1'b0, op1} + {1'b0, op2};
				result   = sum[cpuPkg::dataWidth-1:0];
				carry    = sum[cpuPkg::dataWidth];
				// same signs in, other sign out
				overflow = (op1[cpuPkg::dataWidth-1] == op2[cpuPkg::dataWidth-1]) &&
					(result[cpuPkg::dataWidth-1] != op1[cpuPkg::dataWidth-1]);
			end
			cpuPkg::AluSub: begin
				sum      = {1'b0, op1} + {1'b0, ~op2} + 1'b1; // carry set means no borrow
				result   = sum[cpuPkg::dataWidth-1:0];
				carry    = sum[cpuPkg::dataWidth];
				overflow = (op1[cpuPkg::dataWidth-1] != op2[cpuPkg::dataWidth-1]) &&
					(result[cpuPkg::dataWidth-1] != op1[cpuPkg::dataWidth-1]);
			end
			cpuPkg::AluAnd:   result = op1 & op2;
			cpuPkg::AluOr:    result = op1 | op2;
			cpuPkg::AluXor:   result = op1 ^ op2;
			cpuPkg::AluPassB: result = op2;
			default:          result = op2;
		endcase
	end

	assign flags = {result == '0, result[cpuPkg::dataWidth-1], carry, overflow};

endmodule

// File: hw/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
	input  logic                Clock,
	input  logic                rstN,
	input  cpuPkg::opcodeT      opcode,
	input  logic                zero,
	input  logic                wbAck,
	output logic                wbCyc,
	output logic                wbStb,
	output logic                wbWe,
	output logic                halted,
	output cpuPkg::aluFuncT     aluFunc,
	output cpuPkg::pcSelT       pcSel,
	output cpuPkg::op1SelT      op1Sel,
	output logic                op2Sel,
	output logic                immLong,
	output logic                irWe,
	output logic                pcWe,
	output logic                lrWe,
	output logic                flagWe,
	output logic                regWe,
	output logic                wdSel,
	output logic                rs2Sel,
	output logic                adrSel
);

	cpuPkg::cpuStateT state, nextState;
	cpuPkg::pcSelT    execPcSel;
	logic             regOp;    // register-register alu instruction
	logic             busDone;  // ack of the cycle in flight
	logic             busNext;

	assign busDone = wbCyc && wbAck;
	assign regOp   = opcode inside {cpuPkg::OpAdd, cpuPkg::OpSub, cpuPkg::OpAnd,
		cpuPkg::OpOr, cpuPkg::OpXor};
	assign op2Sel  = regOp;
	assign rs2Sel  = (opcode == cpuPkg::OpStore);
	assign adrSel  = (state == cpuPkg::StMem);
	assign halted  = (state == cpuPkg::StHalt);

	// operand steering depends on the opcode only
	always_comb begin
		aluFunc   = cpuPkg::AluPassB;
		op1Sel    = cpuPkg::Op1Rd1;
		immLong   = 1'b0;
		execPcSel = cpuPkg::PcHold;
		case (opcode)
			cpuPkg::OpAdd: aluFunc = cpuPkg::AluAdd;
			cpuPkg::OpSub: aluFunc = cpuPkg::AluSub;
			cpuPkg::OpAnd: aluFunc = cpuPkg::AluAnd;
			cpuPkg::OpOr:  aluFunc = cpuPkg::AluOr;
			cpuPkg::OpXor: aluFunc = cpuPkg::AluXor;
			cpuPkg::OpAddi, cpuPkg::OpLoad, cpuPkg::OpStore:
				aluFunc = cpuPkg::AluAdd; // rs1 + imm5, also the memory address
			cpuPkg::OpJmp, cpuPkg::OpBz, cpuPkg::OpCall: begin
				aluFunc   = cpuPkg::AluAdd;
				op1Sel    = cpuPkg::Op1Pc;
				immLong   = 1'b1;
				execPcSel = cpuPkg::PcBranch;
			end
			cpuPkg::OpRet: execPcSel = cpuPkg::PcLr;
			default: ;
		endcase
	end

	always_comb begin
		nextState = state;
		pcSel     = cpuPkg::PcHold;
		irWe      = 1'b0;
		pcWe      = 1'b0;
		lrWe      = 1'b0;
		flagWe    = 1'b0;
		regWe     = 1'b0;
		wdSel     = 1'b0;
		case (state)
			cpuPkg::StFetch: begin
				pcSel = cpuPkg::PcInc;
				if (busDone) begin
					irWe      = 1'b1;
					pcWe      = 1'b1;
					nextState = cpuPkg::StDecode;
				end
			end
			cpuPkg::StDecode: nextState = cpuPkg::StExec;
			cpuPkg::StExec: begin
				pcSel     = execPcSel;
				nextState = cpuPkg::StFetch;
				if (regOp || opcode == cpuPkg::OpAddi) begin
					flagWe    = 1'b1;
					nextState = cpuPkg::StWrite;
				end else if (opcode == cpuPkg::OpLoad || opcode == cpuPkg::OpStore) begin
					nextState = cpuPkg::StMem;
				end else if (opcode == cpuPkg::OpHalt) begin
					nextState = cpuPkg::StHalt;
				end else if (execPcSel != cpuPkg::PcHold) begin
					pcWe = (opcode != cpuPkg::OpBz) || zero; // bz falls through on nonzero
					lrWe = (opcode == cpuPkg::OpCall);
				end
			end
			cpuPkg::StMem: begin
				if (busDone)
					nextState = (opcode == cpuPkg::OpLoad) ? cpuPkg::StWrite : cpuPkg::StFetch;
			end
			cpuPkg::StWrite: begin
				regWe     = 1'b1;
				wdSel     = (opcode == cpuPkg::OpLoad);
				nextState = cpuPkg::StFetch;
			end
			cpuPkg::StHalt: nextState = cpuPkg::StHalt;
			default: nextState = cpuPkg::StFetch;
		endcase
	end

	// bus is idle for at least one cycle after every ack
	assign busNext = (nextState == cpuPkg::StFetch || nextState == cpuPkg::StMem) && !busDone;

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			state <= cpuPkg::StFetch;
			wbCyc <= 1'b0;
			wbStb <= 1'b0;
			wbWe  <= 1'b0;
		end else begin
			state <= nextState;
			wbCyc <= busNext;
			wbStb <= busNext;
			wbWe  <= busNext && nextState == cpuPkg::StMem && opcode == cpuPkg::OpStore;
		end
	end

	// a cycle in flight stays up with the same direction until its ack
	assert property (@(posedge Clock) disable iff (!rstN)
		wbCyc && !wbAck |=> wbCyc && wbStb && $stable(wbWe))
		else $error("bus cycle dropped before ack");

	// writes only come from the store's own bus cycle
	assert property (@(posedge Clock) disable iff (!rstN)
		wbWe |-> (state == cpuPkg::StMem && opcode == cpuPkg::OpStore))
		else $error("wbWe outside a store cycle");

endmodule

// File: hw/cpuPkg.sv
package cpuPkg;

	localparam int dataWidth    = 16; // machine word
	localparam int regAddrWidth = 3;  // eight registers

	// taken from ir[15:12]
	typedef enum logic [3:0] {
		OpAdd   = 4'h0,
		OpSub   = 4'h1,
		OpAnd   = 4'h2,
		OpOr    = 4'h3,
		OpXor   = 4'h4,
		OpAddi  = 4'h5,
		OpLoad  = 4'h6,
		OpStore = 4'h7,
		OpJmp   = 4'h8,
		OpBz    = 4'h9,  // branch on zero flag
		OpCall  = 4'hA,
		OpRet   = 4'hB,
		OpHalt  = 4'hC
	} opcodeT;

	typedef enum logic [2:0] {
		AluAdd,
		AluSub,
		AluAnd,
		AluOr,
		AluXor,
		AluPassB
	} aluFuncT;

	typedef enum logic [1:0] {
		PcInc,    // pc + 1
		PcBranch, // pc + extended offset, from the alu
		PcLr,
		PcHold
	} pcSelT;

	typedef enum logic {
		Op1Rd1,
		Op1Pc
	} op1SelT;

	typedef enum logic [2:0] {
		StFetch,
		StDecode,
		StExec,
		StMem,
		StWrite,
		StHalt
	} cpuStateT;

endpackage

// File: hw/cpuTop.sv
`timescale 1ns/1ps

module cpuTop (
	input  logic                          Clock,
	input  logic                          rstN,
	output logic [cpuPkg::dataWidth-1:0]  wbAdr,
	output logic [cpuPkg::dataWidth-1:0]  wbDatO,
	input  logic [cpuPkg::dataWidth-1:0]  wbDatI,
	output logic                          wbWe,
	output logic                          wbCyc,
	output logic                          wbStb,
	input  logic                          wbAck,
	output logic                          halted,
	output logic [3:0]                    flags
);

	cpuPkg::aluFuncT aluFunc;
	cpuPkg::pcSelT   pcSel;
	cpuPkg::op1SelT  op1Sel;
	cpuPkg::opcodeT  opcode;
	logic            op2Sel, immLong, irWe, pcWe, lrWe, flagWe;
	logic            regWe, wdSel, rs2Sel, adrSel, zero;

	datapath datapath_i (
		.Clock   (Clock   ),
		.rstN    (rstN    ),
		.aluFunc (aluFunc ),
		.pcSel   (pcSel   ),
		.op1Sel  (op1Sel  ),
		.op2Sel  (op2Sel  ),
		.immLong (immLong ),
		.irWe    (irWe    ),
		.pcWe    (pcWe    ),
		.lrWe    (lrWe    ),
		.flagWe  (flagWe  ),
		.regWe   (regWe   ),
		.wdSel   (wdSel   ),
		.rs2Sel  (rs2Sel  ),
		.adrSel  (adrSel  ),
		.wbDatI  (wbDatI  ),
		.wbAdr   (wbAdr   ),
		.wbDatO  (wbDatO  ),
		.opcode  (opcode  ),
		.zero    (zero    ),
		.flags   (flags   )
	);

	controlUnit controlUnit_i (
		.Clock   (Clock   ),
		.rstN    (rstN    ),
		.opcode  (opcode  ),
		.zero    (zero    ),
		.wbAck   (wbAck   ),
		.wbCyc   (wbCyc   ),
		.wbStb   (wbStb   ),
		.wbWe    (wbWe    ),
		.halted  (halted  ),
		.aluFunc (aluFunc ),
		.pcSel   (pcSel   ),
		.op1Sel  (op1Sel  ),
		.op2Sel  (op2Sel  ),
		.immLong (immLong ),
		.irWe    (irWe    ),
		.pcWe    (pcWe    ),
		.lrWe    (lrWe    ),
		.flagWe  (flagWe  ),
		.regWe   (regWe   ),
		.wdSel   (wdSel   ),
		.rs2Sel  (rs2Sel  ),
		.adrSel  (adrSel  )
	);

endmodule

// File: hw/datapath.sv
`timescale 1ns/1ps

module datapath (
	input  logic                          Clock,
	input  logic                          rstN,
	input  cpuPkg::aluFuncT               aluFunc,
	input  cpuPkg::pcSelT                 pcSel,
	input  cpuPkg::op1SelT                op1Sel,
	input  logic                          op2Sel,   // 1 picks rd2, 0 the extended field
	input  logic                          immLong,  // 12-bit offset instead of 5-bit immediate
	input  logic                          irWe,
	input  logic                          pcWe,
	input  logic                          lrWe,
	input  logic                          flagWe,
	input  logic                          regWe,
	input  logic                          wdSel,    // 1 writes back bus data
	input  logic                          rs2Sel,   // 1 reads the store register ir[2:0]
	input  logic                          adrSel,   // 1 puts the alu result on the bus
	input  logic [cpuPkg::dataWidth-1:0]  wbDatI,
	output logic [cpuPkg::dataWidth-1:0]  wbAdr,
	output logic [cpuPkg::dataWidth-1:0]  wbDatO,
	output cpuPkg::opcodeT                opcode,
	output logic                          zero,
	output logic [3:0]                    flags
);

	logic [cpuPkg::dataWidth-1:0]    ir, pc, lr, pcIn;
	logic [cpuPkg::dataWidth-1:0]    extended, op1, op2;
	logic [cpuPkg::dataWidth-1:0]    rd1, rd2, wData, aluResult;
	logic [cpuPkg::dataWidth-1:0]    memData;
	logic [cpuPkg::regAddrWidth-1:0] rs2;
	logic [3:0]                      aluFlags;

	assign opcode = cpuPkg::opcodeT'(ir[15:12]);
	assign zero   = flags[3];

	assign extended = immLong ? {{4{ir[11]}}, ir[11:0]} : {{11{ir[10]}}, ir[10:6]};
	assign op1      = (op1Sel == cpuPkg::Op1Pc) ? pc : rd1;
	assign op2      = op2Sel ? rd2 : extended;
	assign rs2      = rs2Sel ? ir[2:0] : ir[8:6];
	assign wData    = wdSel ? memData : aluResult;

	// system bus side
	assign wbAdr  = adrSel ? aluResult : pc;
	assign wbDatO = rd2;

	always_comb begin
		case (pcSel)
			cpuPkg::PcInc:    pcIn = pc + 1'b1;
			cpuPkg::PcBranch: pcIn = aluResult; // pc already points past the branch
			cpuPkg::PcLr:     pcIn = lr;
			default:          pcIn = pc;
		endcase
	end

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			ir    <= '0;
			pc    <= '0;
			lr    <= '0;
			flags <= '0;
		end else begin
			if (irWe)
				ir <= wbDatI;
			if (pcWe)
				pc <= pcIn;
			if (lrWe)
				lr <= pc; // return address, taken before the branch lands
			if (flagWe)
				flags <= aluFlags;
		end
	end

	// holds the load word from the ack cycle until StWrite
	always_ff @(posedge Clock)
		memData <= wbDatI;

	regBlock regBlock_i (
		.Clock (Clock     ),
		.rstN  (rstN      ),
		.we    (regWe     ),
		.rs1   (ir[5:3]   ),
		.rs2   (rs2       ),
		.rw    (ir[2:0]   ),
		.wData (wData     ),
		.rd1   (rd1       ),
		.rd2   (rd2       )
	);

	alu alu_i (
		.op1    (op1       ),
		.op2    (op2       ),
		.func   (aluFunc   ),
		.result (aluResult ),
		.flags  (aluFlags  )
	);

	// a fetch never overlaps a register writeback
	assert property (@(posedge Clock) disable iff (!rstN) !(irWe && regWe))
		else $error("irWe and regWe high together");

endmodule

// File: hw/regBlock.sv
`timescale 1ns/1ps

module regBlock (
	input  logic                             Clock,
	input  logic                             rstN,
	input  logic                             we,
	input  logic [cpuPkg::regAddrWidth-1:0]  rs1,
	input  logic [cpuPkg::regAddrWidth-1:0]  rs2,
	input  logic [cpuPkg::regAddrWidth-1:0]  rw,
	input  logic [cpuPkg::dataWidth-1:0]     wData,
	output logic [cpuPkg::dataWidth-1:0]     rd1,
	output logic [cpuPkg::dataWidth-1:0]     rd2
);

	logic [cpuPkg::dataWidth-1:0] regs [2**cpuPkg::regAddrWidth];

	// read ports are plain muxes
	assign rd1 = regs[rs1];
	assign rd2 = regs[rs2];

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			for (int i = 0; i < 2**cpuPkg::regAddrWidth; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[rw] <= wData;
		end
	end

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the cpu testbench, the log decides the result
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cpuTb -f sources.f -o cpuSim \
	&& ./obj_dir/cpuSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Testbench failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "no result found in sim.log"; exit 1; }
echo "simulation PASSED"
exit 0

// File: sources.f
hw/cpuPkg.sv
hw/regBlock.sv
hw/alu.sv
hw/datapath.sv
hw/controlUnit.sv
hw/cpuTop.sv
test/wbMemModel.sv
test/cpuTb.sv

// File: test/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;

	// longest run is about 30 executed instructions at up to 15 cycles each,
	// seven runs plus resets stay well under this
	localparam int cycleLimit = 4000;

	logic        Clock;
	logic        rstN;
	logic        randomWaits;
	logic [15:0] wbAdr, wbDatO, wbDatI;
	logic        wbWe, wbCyc, wbStb, wbAck, halted;
	logic [3:0]  flags;

	logic [15:0] image      [256]; // program and data before a run
	logic [15:0] refMem     [256]; // memory of the instruction model
	logic [15:0] savedImage [256];
	logic        refZero;
	logic [3:0]  refFlags;         // {zero, negative, carry, overflow}
	int          cycleCount = 0;
	int          checkCount = 0;
	int          errorCount = 0;
	int          testCount  = 0;
	int          checksBefore, errorsBefore;
	int          writeCount, strayWe;
	logic [15:0] writeAdr;

	cpuTop dut_i (
		.Clock  (Clock  ),
		.rstN   (rstN   ),
		.wbAdr  (wbAdr  ),
		.wbDatO (wbDatO ),
		.wbDatI (wbDatI ),
		.wbWe   (wbWe   ),
		.wbCyc  (wbCyc  ),
		.wbStb  (wbStb  ),
		.wbAck  (wbAck  ),
		.halted (halted ),
		.flags  (flags  )
	);

	wbMemModel memModel (
		.Clock       (Clock       ),
		.rstN        (rstN        ),
		.randomWaits (randomWaits ),
		.adr         (wbAdr       ),
		.datI        (wbDatO      ),
		.datO        (wbDatI      ),
		.we          (wbWe        ),
		.cyc         (wbCyc       ),
		.stb         (wbStb       ),
		.ack         (wbAck       )
	);

	initial begin
		Clock = 1'b0;
		forever #50 Clock = ~Clock;
	end

	always @(posedge Clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("timeout after %0d cycles, the DUT did not reach halt", cycleCount);
			$display("Testbench failed");
			$finish;
		end
	end

	// bus write monitor
	always @(posedge Clock) begin
		if (!rstN) begin
			writeCount <= 0;
			strayWe    <= 0;
		end else begin
			if (wbCyc && wbAck && wbWe) begin
				writeCount <= writeCount + 1;
				writeAdr   <= wbAdr;
			end
			if (wbWe && !(wbCyc && wbStb))
				strayWe <= strayWe + 1;
		end
	end

	function automatic logic [15:0] rOp(input cpuPkg::opcodeT op, input int rd, input int rs1,
		input int rs2);
		return {op, 3'b000, rs2[2:0], rs1[2:0], rd[2:0]};
	endfunction

	// also stores, with the data register in the rd field
	function automatic logic [15:0] iOp(input cpuPkg::opcodeT op, input int rd, input int rs1,
		input int imm);
		return {op, 1'b0, imm[4:0], rs1[2:0], rd[2:0]};
	endfunction

	function automatic logic [15:0] jOp(input cpuPkg::opcodeT op, input int offset);
		return {op, offset[11:0]};
	endfunction

	task automatic checkValue(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		checkCount++;
		if (expected !== actual) begin
			errorCount++;
			$display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	task automatic newTest();
		checksBefore = checkCount;
		errorsBefore = errorCount;
		for (int i = 0; i < 256; i++)
			image[i] = {8'hC3, i[7:0]};
	endtask

	task automatic reportTest(input string name);
		testCount++;
		$display("%-18s %0d checks, %0d errors", name, checkCount - checksBefore,
			errorCount - errorsBefore);
	endtask

	// instruction set model working on refMem
	task automatic modelProgram();
		logic [15:0]    r [8];
		logic [15:0]    pc, lr, ir, a, b, imm, res, off;
		cpuPkg::opcodeT op;
		logic           done;
		int             steps;
		int             sa, sb;
		pc       = '0;
		lr       = '0;
		refZero  = 1'b0;
		refFlags = '0;
		done     = 1'b0;
		steps    = 0;
		for (int i = 0; i < 8; i++)
			r[i] = '0;
		while (!done && steps < 500) begin
			ir  = refMem[pc[7:0]];
			op  = cpuPkg::opcodeT'(ir[15:12]);
			pc  = pc + 16'd1;
			a   = r[ir[5:3]];
			b   = r[ir[8:6]];
			imm = {{11{ir[10]}}, ir[10:6]};
			off = {{4{ir[11]}}, ir[11:0]};
			res = a + imm; // addi result and memory address
			case (op)
				cpuPkg::OpAdd:   res = a + b;
				cpuPkg::OpSub:   res = a - b;
				cpuPkg::OpAnd:   res = a & b;
				cpuPkg::OpOr:    res = a | b;
				cpuPkg::OpXor:   res = a ^ b;
				cpuPkg::OpLoad:  r[ir[2:0]] = refMem[res[7:0]];
				cpuPkg::OpStore: refMem[res[7:0]] = r[ir[2:0]];
				cpuPkg::OpJmp:   pc = pc + off;
				cpuPkg::OpBz:    pc = refZero ? pc + off : pc;
				cpuPkg::OpCall: begin
					lr = pc;
					pc = pc + off;
				end
				cpuPkg::OpRet:   pc = lr;
				cpuPkg::OpHalt:  done = 1'b1;
				default: ;
			endcase
			if (op inside {cpuPkg::OpAdd, cpuPkg::OpSub, cpuPkg::OpAnd, cpuPkg::OpOr,
				cpuPkg::OpXor, cpuPkg::OpAddi}) begin
				if (op == cpuPkg::OpAddi)
					b = imm;
				sa         = $signed(a);
				sb         = $signed(b);
				r[ir[2:0]] = res;
				refZero    = (res == 16'd0);
				refFlags   = {refZero, res[15], 2'b00};
				// carry and overflow only for add and subtract
				if (op == cpuPkg::OpAdd || op == cpuPkg::OpAddi) begin
					refFlags[1] = (int'(a) + int'(b)) > 65535;
					refFlags[0] = (sa + sb) > 32767 || (sa + sb) < -32768;
				end else if (op == cpuPkg::OpSub) begin
					refFlags[1] = (a >= b); // no borrow
					refFlags[0] = (sa - sb) > 32767 || (sa - sb) < -32768;
				end
			end
			steps++;
		end
		if (!done) begin
			errorCount++;
			$display("instruction model ran %0d steps without reaching HALT", steps);
		end
	endtask

	task automatic runProgram(input logic waitsOn);
		@(posedge Clock);
		rstN        <= 1'b0;
		randomWaits <= waitsOn;
		for (int i = 0; i < 256; i++) begin
			memModel.mem[i] <= image[i];
			refMem[i]       = image[i];
		end
		repeat (5) @(posedge Clock);
		rstN <= 1'b1;
		do
			@(negedge Clock);
		while (!halted);
		modelProgram();
	endtask

	task automatic compareImage();
		for (int i = 0; i < 256; i++)
			checkValue($sformatf("mem[%02h]", i), refMem[i], memModel.mem[i]);
		checkValue("flags", {12'd0, refFlags}, {12'd0, flags});
	endtask

	task automatic aluOps();
		newTest();
		image[0]  = iOp(cpuPkg::OpAddi, 1, 0, 13);
		image[1]  = iOp(cpuPkg::OpAddi, 2, 0, -6);
		image[2]  = rOp(cpuPkg::OpAdd, 3, 1, 2);
		image[3]  = rOp(cpuPkg::OpSub, 4, 1, 2);
		image[4]  = rOp(cpuPkg::OpAnd, 5, 1, 2);
		image[5]  = rOp(cpuPkg::OpOr, 6, 1, 2);
		image[6]  = rOp(cpuPkg::OpXor, 7, 1, 2);
		for (int i = 0; i < 5; i++)
			image[7 + i] = iOp(cpuPkg::OpStore, 3 + i, 0, i - 16); // words f0 to f4
		image[12] = jOp(cpuPkg::OpHalt, 0);
		runProgram(1'b0);
		checkValue("mem[f0] add", 16'h0007, memModel.mem[8'hF0]);
		checkValue("mem[f1] sub", 16'h0013, memModel.mem[8'hF1]);
		checkValue("mem[f2] and", 16'h0008, memModel.mem[8'hF2]);
		checkValue("mem[f3] or", 16'hFFFF, memModel.mem[8'hF3]);
		checkValue("mem[f4] xor", 16'hFFF7, memModel.mem[8'hF4]);
		compareImage();
		reportTest("aluOps");
	endtask

	task automatic negativeImmediate();
		newTest();
		image[0] = iOp(cpuPkg::OpAddi, 1, 0, -3);
		image[1] = iOp(cpuPkg::OpStore, 1, 0, -16);
		image[2] = iOp(cpuPkg::OpAddi, 2, 0, 5);
		image[3] = rOp(cpuPkg::OpSub, 4, 2, 2); // zero result
		image[4] = jOp(cpuPkg::OpHalt, 0);
		runProgram(1'b0);
		checkValue("mem[f0]", 16'hFFFD, memModel.mem[8'hF0]);
		checkValue("flags.zero", 16'd1, {15'd0, flags[3]});
		compareImage();
		reportTest("negativeImmediate");
	endtask

	task automatic loadStoreCopy();
		newTest();
		image[8'hF8] = 16'h5A3C;
		image[0]     = iOp(cpuPkg::OpLoad, 1, 0, -8);
		image[1]     = iOp(cpuPkg::OpStore, 1, 0, -4);
		image[2]     = jOp(cpuPkg::OpHalt, 0);
		runProgram(1'b0);
		checkValue("mem[fc]", 16'h5A3C, memModel.mem[8'hFC]);
		checkValue("write count", 16'd1, 16'(writeCount));
		checkValue("write address", 16'hFFFC, writeAdr);
		checkValue("wbWe outside bus cycle", 16'd0, 16'(strayWe));
		compareImage();
		reportTest("loadStoreCopy");
	endtask

	task automatic branchOnZero();
		newTest();
		image[0] = iOp(cpuPkg::OpAddi, 1, 0, 4);
		image[1] = rOp(cpuPkg::OpSub, 2, 1, 1);
		image[2] = jOp(cpuPkg::OpBz, 1);           // taken
		image[3] = iOp(cpuPkg::OpStore, 1, 0, -16); // skipped
		image[4] = iOp(cpuPkg::OpAddi, 3, 0, 7);
		image[5] = jOp(cpuPkg::OpBz, 1);           // not taken
		image[6] = iOp(cpuPkg::OpStore, 3, 0, -15);
		image[7] = jOp(cpuPkg::OpHalt, 0);
		runProgram(1'b0);
		checkValue("mem[f0] untouched", 16'hC3F0, memModel.mem[8'hF0]);
		checkValue("mem[f1]", 16'h0007, memModel.mem[8'hF1]);
		compareImage();
		reportTest("branchOnZero");
	endtask

	task automatic callReturn();
		newTest();
		image[0] = iOp(cpuPkg::OpAddi, 1, 0, 9);
		image[1] = jOp(cpuPkg::OpCall, 3);         // to 5
		image[2] = iOp(cpuPkg::OpStore, 1, 0, -15); // after the return
		image[3] = jOp(cpuPkg::OpHalt, 0);
		image[4] = jOp(cpuPkg::OpHalt, 0);
		image[5] = iOp(cpuPkg::OpAddi, 2, 0, -1);
		image[6] = iOp(cpuPkg::OpStore, 2, 0, -16);
		image[7] = jOp(cpuPkg::OpRet, 0);
		runProgram(1'b0);
		checkValue("mem[f0] subroutine", 16'hFFFF, memModel.mem[8'hF0]);
		checkValue("mem[f1] after call", 16'h0009, memModel.mem[8'hF1]);
		compareImage();
		reportTest("callReturn");
	endtask

	task automatic waitStateCompare();
		newTest();
		image[0]  = iOp(cpuPkg::OpAddi, 1, 0, 5);
		image[1]  = iOp(cpuPkg::OpAddi, 2, 0, -7);
		image[2]  = iOp(cpuPkg::OpAddi, 7, 0, 3);    // loop count
		image[3]  = rOp(cpuPkg::OpAdd, 3, 1, 2);
		image[4]  = rOp(cpuPkg::OpXor, 1, 3, 1);
		image[5]  = iOp(cpuPkg::OpStore, 3, 7, -16);
		image[6]  = iOp(cpuPkg::OpAddi, 7, 7, -1);
		image[7]  = jOp(cpuPkg::OpBz, 1);
		image[8]  = jOp(cpuPkg::OpJmp, -6);         // back to 3
		image[9]  = iOp(cpuPkg::OpLoad, 5, 0, -14);
		image[10] = rOp(cpuPkg::OpOr, 6, 5, 1);
		image[11] = jOp(cpuPkg::OpCall, 4);         // to 16
		image[12] = iOp(cpuPkg::OpStore, 6, 0, -4);
		image[13] = rOp(cpuPkg::OpAnd, 4, 6, 2);
		image[14] = iOp(cpuPkg::OpStore, 4, 0, -3);
		image[15] = jOp(cpuPkg::OpHalt, 0);
		image[16] = rOp(cpuPkg::OpSub, 4, 1, 2);
		image[17] = iOp(cpuPkg::OpStore, 4, 0, -5);
		image[18] = jOp(cpuPkg::OpRet, 0);
		runProgram(1'b0);
		compareImage();
		for (int i = 0; i < 256; i++)
			savedImage[i] = memModel.mem[i];
		runProgram(1'b1);
		compareImage();
		for (int i = 0; i < 256; i++)
			checkValue($sformatf("waited mem[%02h]", i), savedImage[i], memModel.mem[i]);
		reportTest("waitStateCompare");
	endtask

	initial begin
		rstN        = 1'b0;
		randomWaits = 1'b0;
		aluOps();
		negativeImmediate();
		loadStoreCopy();
		branchOnZero();
		callReturn();
		waitStateCompare();
		$display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: test/wbMemModel.sv
`timescale 1ns/1ps

module wbMemModel (
	input  logic         Clock,
	input  logic         rstN,
	input  logic         randomWaits, // low gives the shortest ack
	input  logic [15:0]  adr,
	input  logic [15:0]  datI,
	output logic [15:0]  datO,
	input  logic         we,
	input  logic         cyc,
	input  logic         stb,
	output logic         ack
);

	logic [15:0] mem [256];
	logic [31:0] lfsr = 32'h5e15b841;
	logic        active;   // a bus cycle has been seen
	logic [1:0]  waitLeft;

	// one step of a right shifting galois lfsr
	function automatic logic [31:0] lfsrStep(input logic [31:0] value);
		return value[0] ? ((value >> 1) ^ 32'h80200003) : (value >> 1);
	endfunction

	assign datO = mem[adr[7:0]]; // word addressed, upper bits alias

	always @(posedge Clock) begin
		logic [31:0] step1;
		logic [31:0] step2;
		step1 = lfsrStep(lfsr);
		step2 = lfsrStep(step1);
		if (!rstN) begin
			ack    <= 1'b0;
			active <= 1'b0;
		end else if (ack) begin
			ack    <= 1'b0;
			active <= 1'b0;
		end else if (cyc && stb) begin
			if (!active) begin
				active <= 1'b1;
				if (randomWaits) begin
					waitLeft <= {lfsr[0], step1[0]}; // one step per bit
					lfsr     <= step2;
				end else begin
					waitLeft <= 2'd0;
				end
			end else if (waitLeft == 2'd0) begin
				ack <= 1'b1;
				if (we)
					mem[adr[7:0]] <= datI;
			end else begin
				waitLeft <= waitLeft - 2'd1;
			end
		end
	end

endmodule
